// File: Makefile
# Verilator flow for the router ingress block

LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f router_ingress.f --top-module router_ingress

sim:
	rm -f $(LOG)
	verilator --binary --timing -f router_ingress.f --top-module router_ingress_tb \
		-o router_ingress_sim
	-./obj_dir/router_ingress_sim > $(LOG) 2>&1
	cat $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: design/ing_arbiter.sv
// Ingress round-robin arbiter
// Merges whole buffered packets onto the output bus and tags each beat with its port

`timescale 1ns/1ns
`default_nettype none

`include "ing_settings.svh"

module ing_arbiter (
    input  logic                           core_clk_ifc,
    input  logic                           packet_sink_reset,
    input  logic [`ING_NUM_PORTS-1:0]      pkt_avail,
    input  ing_pkg::ing_beat_t             head_beat [`ING_NUM_PORTS],
    output logic [`ING_NUM_PORTS-1:0]      pop,
    output logic                           out_valid,
    output logic                           out_last,
    output ing_pkg::ing_data_t             out_data,
    output ing_pkg::ing_port_t             out_port,
    input  logic                           out_ready
);

    import ing_pkg::*;

    logic      busy;
    ing_port_t owner;
    ing_port_t rr_ptr;
    ing_port_t pick;
    logic      pick_valid;
    ing_beat_t cur_beat;

    ////////////////////////////////////////
    // Round-robin search

    // Starts one past the last grant, so the last grant is checked last
    always_comb begin
        int idx;
        pick       = rr_ptr;
        pick_valid = 1'b0;
        for (int k = 1; k <= `ING_NUM_PORTS; k++) begin
            idx = (int'(rr_ptr) + k) % `ING_NUM_PORTS;
            if (!pick_valid && pkt_avail[idx]) begin
                pick       = ing_port_t'(idx);
                pick_valid = 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // Grant state

    always_ff @(posedge core_clk_ifc) begin
        if (packet_sink_reset) begin
            busy   <= 1'b0;
            owner  <= '0;
            rr_ptr <= ing_port_t'(`ING_NUM_PORTS - 1);
        end else if (!busy) begin
            if (pick_valid) begin
                busy   <= 1'b1;
                owner  <= pick;
                rr_ptr <= pick;
            end
        end else if (out_ready && out_last) begin
            // Grant ends on the last beat, an idle cycle follows
            busy <= 1'b0;
        end
    end

    // Output routing
    assign cur_beat  = head_beat[owner];
    assign out_valid = busy;
    assign out_data  = cur_beat.data;
    assign out_last  = cur_beat.last;
    assign out_port  = owner;

    always_comb begin
        for (int i = 0; i < `ING_NUM_PORTS; i++) begin
            pop[i] = busy && out_ready && (owner == ing_port_t'(i));
        end
    end

    // Held beat must not move while the sink stalls
    a_out_stable: assert property (@(posedge core_clk_ifc) disable iff (packet_sink_reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last)
                                    && $stable(out_port));

endmodule

`default_nettype wire

// File: design/ing_fifo.sv
// Port buffer FIFO
// Circular store of beats with a head view and a fill level

`timescale 1ns/1ns
`default_nettype none

`include "ing_settings.svh"

module ing_fifo (
    input  logic                core_clk_ifc,
    input  logic                packet_sink_reset,
    input  logic                wr_en,
    input  ing_pkg::ing_beat_t  wr_beat,
    input  logic                rd_en,
    output ing_pkg::ing_beat_t  rd_beat,
    output ing_pkg::ing_level_t level
);

    import ing_pkg::*;

    localparam int PTR_W = $clog2(`ING_BUF_DEPTH);

    ing_beat_t        mem [`ING_BUF_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    ing_level_t       count;

    ////////////////////////////////////////
    // Pointers and fill level

    always_ff @(posedge core_clk_ifc) begin
        if (packet_sink_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + ing_level_t'(wr_en) - ing_level_t'(rd_en);
        end
    end

    // Storage
    always_ff @(posedge core_clk_ifc) begin
        if (wr_en) begin
            mem[wr_ptr] <= wr_beat;
        end
    end

    // Head entry is always visible
    assign rd_beat = mem[rd_ptr];
    assign level   = count;

    a_no_write_full: assert property (@(posedge core_clk_ifc) disable iff (packet_sink_reset)
        wr_en |-> count != ing_level_t'(`ING_BUF_DEPTH));

    a_no_read_empty: assert property (@(posedge core_clk_ifc) disable iff (packet_sink_reset)
        rd_en |-> count != '0);

endmodule

`default_nettype wire

// File: design/ing_pkg.sv
// Router ingress shared types
// Beat payload, stored beat, port tag, counter and FIFO level

`default_nettype none

`include "ing_settings.svh"

package ing_pkg;

    // One beat of payload
    typedef logic [`ING_DATA_WIDTH-1:0] ing_data_t;

    // Entry held in a port buffer
    typedef struct packed {
        ing_data_t data;
        logic      last;
    } ing_beat_t;

    // Ingress port number carried on the output bus
    typedef logic [$clog2(`ING_NUM_PORTS)-1:0] ing_port_t;

    typedef logic [`ING_CNT_WIDTH-1:0] ing_cnt_t;

    // Fill level, zero up to a full buffer inclusive
    typedef logic [$clog2(`ING_BUF_DEPTH + 1)-1:0] ing_level_t;

endpackage

`default_nettype wire

// File: design/ing_port_buffer.sv
// Ingress port buffer
// Enable gating, packet admission, overflow reporting and packet counting for one port

`timescale 1ns/1ns
`default_nettype none

`include "ing_settings.svh"

module ing_port_buffer (
    input  logic               core_clk_ifc,
    input  logic               packet_sink_reset,
    input  logic               in_valid,
    input  logic               in_last,
    input  logic               port_enable,
    input  logic               cnts_clear,
    input  ing_pkg::ing_data_t in_data,
    input  logic               pop,
    output logic               pkt_avail,
    output ing_pkg::ing_beat_t head_beat,
    output ing_pkg::ing_cnt_t  pkt_cnt,
    output logic               buf_overflow
);

    import ing_pkg::*;

    localparam int BEAT_CNT_W = $clog2(`ING_MAX_PKT_BEATS + 1);

    logic                  in_pkt;
    logic                  admit_q;
    logic                  first_beat;
    logic                  room;
    logic                  admit_now;
    logic                  wr_en;
    ing_beat_t             wr_beat;
    ing_level_t            level;
    ing_level_t            pkt_q;
    logic [BEAT_CNT_W-1:0] beat_cnt;

    ////////////////////////////////////////
    // Admission

    assign first_beat = in_valid && !in_pkt;
    // Room left for a maximum-size packet
    assign room       = level <= ing_level_t'(`ING_BUF_DEPTH - `ING_MAX_PKT_BEATS);
    assign admit_now  = port_enable && room;
    assign wr_en      = in_valid && (first_beat ? admit_now : admit_q);
    assign wr_beat    = '{data: in_data, last: in_last};

    always_ff @(posedge core_clk_ifc) begin
        if (packet_sink_reset) begin
            in_pkt       <= 1'b0;
            admit_q      <= 1'b0;
            buf_overflow <= 1'b0;
        end else begin
            // Refused only when enabled, a disabled port drops quietly
            buf_overflow <= first_beat && port_enable && !room;
            if (in_valid) begin
                in_pkt <= !in_last;
            end
            // Decision holds for the rest of the packet
            if (first_beat) begin
                admit_q <= admit_now;
            end
        end
    end

    ing_fifo fifo_inst (
        .core_clk_ifc      (core_clk_ifc),
        .packet_sink_reset (packet_sink_reset),
        .wr_en             (wr_en),
        .wr_beat           (wr_beat),
        .rd_en             (pop),
        .rd_beat           (head_beat),
        .level             (level)
    );

    ////////////////////////////////////////
    // Complete packets and counters

    always_ff @(posedge core_clk_ifc) begin
        if (packet_sink_reset) begin
            pkt_q    <= '0;
            pkt_cnt  <= '0;
            beat_cnt <= '0;
        end else begin
            pkt_q <= pkt_q + ing_level_t'(wr_en && in_last)
                           - ing_level_t'(pop && head_beat.last);
            if (cnts_clear) begin
                pkt_cnt <= '0;
            end else if (wr_en && in_last) begin
                pkt_cnt <= pkt_cnt + 1'b1;
            end
            if (wr_en) begin
                beat_cnt <= in_last ? '0 : beat_cnt + 1'b1;
            end
        end
    end

    assign pkt_avail = pkt_q != '0;

    // Arbiter only drains whole packets
    a_pop_needs_pkt: assert property (@(posedge core_clk_ifc) disable iff (packet_sink_reset)
        pop |-> pkt_avail);

    a_pkt_len: assert property (@(posedge core_clk_ifc) disable iff (packet_sink_reset)
        wr_en |-> beat_cnt < BEAT_CNT_W'(`ING_MAX_PKT_BEATS));

endmodule

`default_nettype wire

// File: design/ing_settings.svh
// Router ingress project-wide sizes
// Port count, beat width, buffer depth, packet limit and counter width

`ifndef ING_SETTINGS_SVH
`define ING_SETTINGS_SVH

// Physical ingress ports
`define ING_NUM_PORTS 4

// Bits per beat on every port and on the output bus
`define ING_DATA_WIDTH 32

// Beats held by each port buffer
`define ING_BUF_DEPTH 64

// Longest legal packet, also the free space needed for admission
`define ING_MAX_PKT_BEATS 16

`define ING_CNT_WIDTH 16

`endif

// File: design/router_ingress.sv
// Router ingress top level
// One buffer per physical port feeding a shared round-robin output

`timescale 1ns/1ns
`default_nettype none

`include "ing_settings.svh"

module router_ingress (
    input  logic                      core_clk_ifc,
    input  logic                      packet_sink_reset,
    input  logic [`ING_NUM_PORTS-1:0] in_valid,
    input  ing_pkg::ing_data_t        in_data [`ING_NUM_PORTS],
    input  logic [`ING_NUM_PORTS-1:0] in_last,
    input  logic [`ING_NUM_PORTS-1:0] port_enable,
    input  logic [`ING_NUM_PORTS-1:0] cnts_clear,
    output ing_pkg::ing_cnt_t         pkt_cnt [`ING_NUM_PORTS],
    output logic [`ING_NUM_PORTS-1:0] buf_overflow,
    output logic                      out_valid,
    output ing_pkg::ing_data_t        out_data,
    output logic                      out_last,
    output ing_pkg::ing_port_t        out_port,
    input  logic                      out_ready
);

    import ing_pkg::*;

    logic [`ING_NUM_PORTS-1:0] pkt_avail;
    logic [`ING_NUM_PORTS-1:0] pop;
    ing_beat_t                 head_beat [`ING_NUM_PORTS];

    ////////////////////////////////////////
    // Per-port buffers

    for (genvar i = 0; i < `ING_NUM_PORTS; i++) begin : g_port
        ing_port_buffer port_buffer_inst (
            .core_clk_ifc      (core_clk_ifc),
            .packet_sink_reset (packet_sink_reset),
            .in_valid          (in_valid[i]),
            .in_last           (in_last[i]),
            .port_enable       (port_enable[i]),
            .cnts_clear        (cnts_clear[i]),
            .in_data           (in_data[i]),
            .pop               (pop[i]),
            .pkt_avail         (pkt_avail[i]),
            .head_beat         (head_beat[i]),
            .pkt_cnt           (pkt_cnt[i]),
            .buf_overflow      (buf_overflow[i])
        );
    end

    // Shared output
    ing_arbiter arbiter_inst (
        .core_clk_ifc      (core_clk_ifc),
        .packet_sink_reset (packet_sink_reset),
        .pkt_avail         (pkt_avail),
        .head_beat         (head_beat),
        .pop               (pop),
        .out_valid         (out_valid),
        .out_last          (out_last),
        .out_data          (out_data),
        .out_port          (out_port),
        .out_ready         (out_ready)
    );

endmodule

`default_nettype wire

// File: router_ingress.f
+incdir+design
design/ing_pkg.sv
design/ing_fifo.sv
design/ing_port_buffer.sv
design/ing_arbiter.sv
design/router_ingress.sv
tb/router_ingress_tb.sv

// File: tb/router_ingress_tb.sv
// Router ingress testbench
// Random packets on all ports, checked against a reference model of admission and ordering

`timescale 1ns/1ns
`default_nettype none

`include "ing_settings.svh"

module router_ingress_tb;

    import ing_pkg::*;

    localparam int TIMEOUT_CYCLES = 20000;
    // Packets that fit before the admission rule refuses one
    localparam int ADMIT_LIMIT = (`ING_BUF_DEPTH - `ING_MAX_PKT_BEATS) / `ING_MAX_PKT_BEATS + 1;

    logic                      core_clk_ifc;
    logic                      packet_sink_reset;
    logic [`ING_NUM_PORTS-1:0] in_valid;
    ing_data_t                 in_data [`ING_NUM_PORTS];
    logic [`ING_NUM_PORTS-1:0] in_last;
    logic [`ING_NUM_PORTS-1:0] port_enable;
    logic [`ING_NUM_PORTS-1:0] cnts_clear;
    ing_cnt_t                  pkt_cnt [`ING_NUM_PORTS];
    logic [`ING_NUM_PORTS-1:0] buf_overflow;
    logic                      out_valid;
    ing_data_t                 out_data;
    logic                      out_last;
    ing_port_t                 out_port;
    logic                      out_ready;

    string     test_name;
    logic [15:0] lfsr;
    int        stim_seq [`ING_NUM_PORTS];
    int        ovf_base [`ING_NUM_PORTS];

    // Reference model state
    ing_beat_t exp_q [`ING_NUM_PORTS][$];
    ing_beat_t new_beat;
    int        mdl_level [`ING_NUM_PORTS];
    int        mdl_seq [`ING_NUM_PORTS];
    int        mdl_idx [`ING_NUM_PORTS];
    int        ovf_count [`ING_NUM_PORTS];
    logic      mdl_in_pkt [`ING_NUM_PORTS];
    logic      mdl_admit [`ING_NUM_PORTS];
    logic      ovf_exp [`ING_NUM_PORTS];
    ing_cnt_t  mdl_cnt [`ING_NUM_PORTS];

    // Comparison state
    ing_beat_t exp_beat;
    logic      stall;
    logic      mid_pkt;
    ing_data_t held_data;
    logic      held_last;
    ing_port_t held_port;
    ing_port_t pkt_port;

    router_ingress router_ingress_inst (
        .core_clk_ifc      (core_clk_ifc),
        .packet_sink_reset (packet_sink_reset),
        .in_valid          (in_valid),
        .in_data           (in_data),
        .in_last           (in_last),
        .port_enable       (port_enable),
        .cnts_clear        (cnts_clear),
        .pkt_cnt           (pkt_cnt),
        .buf_overflow      (buf_overflow),
        .out_valid         (out_valid),
        .out_data          (out_data),
        .out_last          (out_last),
        .out_port          (out_port),
        .out_ready         (out_ready)
    );

    initial begin
        core_clk_ifc = 1'b0;
        forever #2 core_clk_ifc = ~core_clk_ifc;
    end

    ////////////////////////////////////////
    // Helpers

    // Galois LFSR stepped once per bit taken
    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    // Payload of a beat from its port, packet number and position
    function automatic ing_data_t expected_data(input int port, input int seq, input int idx);
        return ing_data_t'({8'(port) ^ 8'hC3, 12'(seq), 12'(idx)});
    endfunction

    task automatic fail_now(input string reason);
        $display("%s", reason);
        $display("TEST FAILED");
        $fatal(1, "stopping on first error");
    endtask

    task automatic check_data(input string name, input ing_data_t exp, input ing_data_t act);
        if (act !== exp) begin
            $display("ERR %s data expected %h actual %h", name, exp, act);
            fail_now("output data mismatch");
        end
    endtask

    task automatic check_port(input string name, input ing_port_t exp, input ing_port_t act);
        if (act !== exp) begin
            $display("ERR %s port expected %0d actual %0d", name, exp, act);
            fail_now("output port tag mismatch");
        end
    endtask

    task automatic check_cnt(input string name, input ing_cnt_t exp, input ing_cnt_t act);
        if (act !== exp) begin
            $display("ERR %s count expected %0d actual %0d", name, exp, act);
            fail_now("counter mismatch");
        end
    endtask

    task automatic check_flag(input string name, input string what, input logic exp,
                              input logic act);
        if (act !== exp) begin
            $display("ERR %s %s expected %0b actual %0b", name, what, exp, act);
            fail_now({what, " mismatch"});
        end
    endtask

    task automatic check_counts();
        @(negedge core_clk_ifc);
        for (int p = 0; p < `ING_NUM_PORTS; p++) begin
            check_cnt(test_name, mdl_cnt[p], pkt_cnt[p]);
        end
    endtask

    task automatic clear_counts(input logic [`ING_NUM_PORTS-1:0] mask);
        @(posedge core_clk_ifc);
        cnts_clear <= mask;
        @(posedge core_clk_ifc);
        cnts_clear <= '0;
    endtask

    // Packets on all ports at once with an optional stop at each port's first refusal
    task automatic send_traffic(input int pkts, input logic full_len, input logic random_ready,
                                input logic stop_on_ovf);
        int   left [`ING_NUM_PORTS];
        int   idx [`ING_NUM_PORTS];
        int   sent [`ING_NUM_PORTS];
        int   cycles;
        logic active;
        logic more;
        for (int p = 0; p < `ING_NUM_PORTS; p++) begin
            left[p] = 0;
            idx[p]  = 0;
            sent[p] = 0;
        end
        cycles = 0;
        active = 1'b1;
        while (active) begin
            @(posedge core_clk_ifc);
            active = 1'b0;
            for (int p = 0; p < `ING_NUM_PORTS; p++) begin
                more = sent[p] < pkts && !(stop_on_ovf && ovf_count[p] != ovf_base[p]);
                if (left[p] == 0 && more && rand_bits(1) != 0) begin
                    left[p] = full_len ? `ING_MAX_PKT_BEATS
                        : rand_bits($clog2(`ING_MAX_PKT_BEATS)) % `ING_MAX_PKT_BEATS + 1;
                    idx[p]  = 0;
                    sent[p]++;
                end
                if (left[p] > 0) begin
                    in_valid[p] <= 1'b1;
                    in_data[p]  <= expected_data(p, stim_seq[p], idx[p]);
                    in_last[p]  <= (left[p] == 1);
                    idx[p]++;
                    left[p]--;
                    if (left[p] == 0) begin
                        stim_seq[p]++;
                    end
                    active = 1'b1;
                end else begin
                    in_valid[p] <= 1'b0;
                    in_last[p]  <= 1'b0;
                    active = active || more;
                end
            end
            if (random_ready) begin
                out_ready <= (rand_bits(1) != 0);
            end
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                fail_now("input traffic did not finish before the timeout");
            end
        end
        @(posedge core_clk_ifc);
        in_valid <= '0;
        in_last  <= '0;
    endtask

    task automatic drain(input logic random_ready);
        int   cycles;
        logic pending;
        cycles  = 0;
        pending = 1'b1;
        while (pending) begin
            @(posedge core_clk_ifc);
            out_ready <= random_ready ? (rand_bits(1) != 0) : 1'b1;
            pending = out_valid;
            for (int p = 0; p < `ING_NUM_PORTS; p++) begin
                pending = pending || exp_q[p].size() != 0;
            end
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                fail_now("expected packets did not leave the output before the timeout");
            end
        end
    endtask

    ////////////////////////////////////////
    // Reference model of admission, overflow and counters

    always @(posedge core_clk_ifc) begin
        if (packet_sink_reset) begin
            for (int p = 0; p < `ING_NUM_PORTS; p++) begin
                exp_q[p].delete();
                mdl_level[p]  = 0;
                mdl_seq[p]    = 0;
                mdl_idx[p]    = 0;
                ovf_count[p]  = 0;
                mdl_in_pkt[p] = 1'b0;
                mdl_admit[p]  = 1'b0;
                ovf_exp[p]    = 1'b0;
                mdl_cnt[p]    = '0;
            end
        end else begin
            for (int p = 0; p < `ING_NUM_PORTS; p++) begin
                check_flag(test_name, $sformatf("overflow port %0d", p), ovf_exp[p],
                           buf_overflow[p]);
                if (buf_overflow[p]) begin
                    ovf_count[p]++;
                end
                ovf_exp[p] = 1'b0;
                if (in_valid[p]) begin
                    // Decision taken on the first beat only
                    if (!mdl_in_pkt[p]) begin
                        mdl_admit[p] = port_enable[p]
                                       && mdl_level[p] + `ING_MAX_PKT_BEATS <= `ING_BUF_DEPTH;
                        ovf_exp[p]   = port_enable[p]
                                       && mdl_level[p] + `ING_MAX_PKT_BEATS > `ING_BUF_DEPTH;
                    end
                    if (mdl_admit[p]) begin
                        new_beat.data = expected_data(p, mdl_seq[p], mdl_idx[p]);
                        new_beat.last = in_last[p];
                        exp_q[p].push_back(new_beat);
                        mdl_level[p]++;
                    end
                    mdl_idx[p]    = in_last[p] ? 0 : mdl_idx[p] + 1;
                    mdl_seq[p]    = in_last[p] ? mdl_seq[p] + 1 : mdl_seq[p];
                    mdl_in_pkt[p] = !in_last[p];
                end
                if (out_valid && out_ready && out_port == ing_port_t'(p)) begin
                    mdl_level[p]--;
                end
                if (cnts_clear[p]) begin
                    mdl_cnt[p] = '0;
                end else if (in_valid[p] && in_last[p] && mdl_admit[p]) begin
                    mdl_cnt[p] = mdl_cnt[p] + 1'b1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Output comparison

    always @(posedge core_clk_ifc) begin
        if (packet_sink_reset) begin
            stall   = 1'b0;
            mid_pkt = 1'b0;
        end else begin
            // Held beat under back-pressure
            if (stall) begin
                if (!out_valid) begin
                    fail_now("out_valid dropped while the output was stalled");
                end
                check_data(test_name, held_data, out_data);
                check_port(test_name, held_port, out_port);
                check_flag(test_name, "held last", held_last, out_last);
            end
            if (out_valid && out_ready) begin
                if (exp_q[out_port].size() == 0) begin
                    fail_now("an output beat came from a port with no admitted packet");
                end
                exp_beat = exp_q[out_port].pop_front();
                if (mid_pkt) begin
                    check_port(test_name, pkt_port, out_port);
                end
                check_data(test_name, exp_beat.data, out_data);
                check_flag(test_name, "last", exp_beat.last, out_last);
                mid_pkt  = !out_last;
                pkt_port = out_port;
            end
            stall     = out_valid && !out_ready;
            held_data = out_data;
            held_last = out_last;
            held_port = out_port;
        end
    end

    ////////////////////////////////////////
    // Test sequence

    initial begin
        lfsr              = 16'(55585);
        packet_sink_reset = 1'b1;
        in_valid          = '0;
        in_last           = '0;
        port_enable       = '1;
        cnts_clear        = '0;
        out_ready         = 1'b1;
        test_name         = "reset";
        for (int p = 0; p < `ING_NUM_PORTS; p++) begin
            in_data[p]  = '0;
            stim_seq[p] = 0;
            ovf_base[p] = 0;
        end
        repeat (2) @(posedge core_clk_ifc);
        packet_sink_reset <= 1'b0;

        test_name = "all_ports";
        send_traffic(6, 1'b0, 1'b0, 1'b0);
        drain(1'b0);
        check_counts();

        test_name = "backpressure";
        send_traffic(6, 1'b0, 1'b1, 1'b0);
        drain(1'b1);
        check_counts();

        test_name = "ports_disabled";
        clear_counts('1);
        port_enable <= '0;
        send_traffic(3, 1'b0, 1'b0, 1'b0);
        drain(1'b0);
        check_counts();
        port_enable <= 4'b1110;
        send_traffic(4, 1'b0, 1'b0, 1'b0);
        drain(1'b0);
        check_counts();
        check_cnt(test_name, '0, pkt_cnt[0]);

        test_name = "counters";
        port_enable <= '1;
        clear_counts('1);
        send_traffic(5, 1'b0, 1'b0, 1'b0);
        drain(1'b0);
        check_counts();
        begin : clear_one
            int                        c;
            logic [`ING_NUM_PORTS-1:0] mask;
            c       = rand_bits(2) % `ING_NUM_PORTS;
            mask    = '0;
            mask[c] = 1'b1;
            clear_counts(mask);
            check_counts();
            check_cnt(test_name, '0, pkt_cnt[c]);
        end

        test_name = "overflow_recovery";
        clear_counts('1);
        @(posedge core_clk_ifc);
        out_ready <= 1'b0;
        @(negedge core_clk_ifc);
        for (int p = 0; p < `ING_NUM_PORTS; p++) begin
            ovf_base[p] = ovf_count[p];
        end
        send_traffic(2 * ADMIT_LIMIT, 1'b1, 1'b0, 1'b1);
        check_counts();
        for (int p = 0; p < `ING_NUM_PORTS; p++) begin
            check_cnt(test_name, ing_cnt_t'(ADMIT_LIMIT), pkt_cnt[p]);
            check_cnt(test_name, ing_cnt_t'(1), ing_cnt_t'(ovf_count[p] - ovf_base[p]));
        end
        drain(1'b0);
        send_traffic(6, 1'b0, 1'b0, 1'b0);
        drain(1'b0);
        check_counts();

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire
